//--- logic/trs_io_pkg.sv
package trs_io_pkg;

  // Z80 address bus width
  localparam int bus_addr_w = 16;

  typedef logic [7:0] byte_t;

  // Host command codes
  // Any code not listed here is ignored
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    bram_poke           = 8'd1,
    bram_peek           = 8'd2,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    xray_resume         = 8'd13,
    get_version         = 8'd15
  } cmd_e;

  // Card identity byte
  localparam byte_t cookie = 8'haf;

  // Major in [7:5], minor in [4:0]
  localparam byte_t version_byte = {3'd0, 5'd2};

  // Parameter bytes in arrival order
  // First byte received lands in the top byte
  typedef union packed {
    struct packed {
      byte_t addr_lo;
      byte_t addr_hi;
      byte_t data;
    } ram_view;
    struct packed {
      byte_t slot;
      byte_t addr_lo;
      byte_t addr_hi;
    } bp_view;
  } cmd_params_u;

endpackage

//--- logic/spi_cmd_link.sv
module spi_cmd_link (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  output logic              miso,
  input  trs_io_pkg::byte_t tx_byte,
  input  logic              tx_load,
  output trs_io_pkg::byte_t rx_byte,
  output logic              rx_valid,
  output logic              frame_start
);

  logic [2:0]        sck_r;
  logic [2:0]        cs_r;
  logic [1:0]        mosi_r;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_active;
  logic [2:0]        bit_cnt;
  trs_io_pkg::byte_t rx_shift;
  trs_io_pkg::byte_t tx_hold;
  trs_io_pkg::byte_t tx_shift;
  logic              tx_pend;

  // Synchronizers
  // MOSI is two deep so it lines up with sck_r[1]
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_r  <= '0;
      cs_r   <= '1;
      mosi_r <= '0;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise    = (sck_r[2:1] == 2'b01);
  assign sck_fall    = (sck_r[2:1] == 2'b10);
  assign cs_active   = ~cs_r[1];
  assign frame_start = (cs_r[2:1] == 2'b10);

  // Bit counter restarts whenever CS is released
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_r[1]};
    end
  end

  assign rx_byte = rx_shift;

  always_ff @(posedge clk) begin
    if (tx_load) begin
      tx_hold <= tx_byte;
    end
  end

  // Reply byte goes out on the falling edge after the load
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_pend  <= 1'b0;
      tx_shift <= '0;
    end else if (!cs_active) begin
      tx_pend  <= 1'b0;
      tx_shift <= '0;
    end else begin
      if (sck_fall) begin
        if (tx_pend) begin
          tx_shift <= tx_hold;
          tx_pend  <= 1'b0;
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
      if (tx_load) begin
        tx_pend <= 1'b1;
      end
    end
  end

  assign miso = tx_shift[7];

  a_rx_valid_single : assert property (
    @(posedge clk) disable iff (!arst_n) rx_valid |=> !rx_valid
  );

endmodule

//--- logic/cmd_parser.sv
module cmd_parser (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  trs_io_pkg::byte_t                      rx_byte,
  input  logic                                   rx_valid,
  input  logic                                   frame_start,
  output trs_io_pkg::byte_t                      tx_byte,
  output logic                                   tx_load,
  output logic                                   host_rd,
  output logic                                   host_wr,
  output logic [trs_io_pkg::bus_addr_w-1:0]      host_addr,
  output trs_io_pkg::byte_t                      host_wdata,
  input  trs_io_pkg::byte_t                      host_rdata,
  input  logic                                   host_rdata_valid,
  output trs_io_pkg::cmd_params_u                params,
  output logic                                   bp_set,
  output logic                                   bp_clear,
  output logic                                   bp_enable,
  output logic                                   bp_disable,
  output logic                                   resume
);

  localparam logic st_idle   = 1'b0;
  localparam logic st_params = 1'b1;

  logic              state;
  trs_io_pkg::byte_t cmd;
  logic [1:0]        bytes_left;
  logic [1:0]        idx;
  logic              reply_load;
  trs_io_pkg::byte_t reply_byte;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      cmd        <= '0;
      bytes_left <= '0;
      idx        <= '0;
      reply_load <= 1'b0;
      host_rd    <= 1'b0;
      host_wr    <= 1'b0;
      bp_set     <= 1'b0;
      bp_clear   <= 1'b0;
      bp_enable  <= 1'b0;
      bp_disable <= 1'b0;
      resume     <= 1'b0;
    end else begin
      reply_load <= 1'b0;
      host_rd    <= 1'b0;
      host_wr    <= 1'b0;
      bp_set     <= 1'b0;
      bp_clear   <= 1'b0;
      bp_enable  <= 1'b0;
      bp_disable <= 1'b0;
      resume     <= 1'b0;
      if (frame_start) begin
        state <= st_idle;
      end else if (rx_valid) begin
        if (state == st_idle) begin
          cmd <= rx_byte;
          idx <= '0;
          case (rx_byte)
            trs_io_pkg::get_cookie,
            trs_io_pkg::get_version: reply_load <= 1'b1;
            trs_io_pkg::bram_poke,
            trs_io_pkg::set_breakpoint: begin
              bytes_left <= 2'd3;
              state      <= st_params;
            end
            trs_io_pkg::bram_peek: begin
              bytes_left <= 2'd2;
              state      <= st_params;
            end
            trs_io_pkg::clear_breakpoint: begin
              bytes_left <= 2'd1;
              state      <= st_params;
            end
            trs_io_pkg::enable_breakpoints: bp_enable <= 1'b1;
            trs_io_pkg::disable_breakpoints: bp_disable <= 1'b1;
            trs_io_pkg::xray_resume: resume <= 1'b1;
            default: ;
          endcase
        end else begin
          idx        <= idx + 2'd1;
          bytes_left <= bytes_left - 2'd1;
          // Last parameter byte fires the action
          if (bytes_left == 2'd1) begin
            state <= st_idle;
            case (cmd)
              trs_io_pkg::bram_poke:        host_wr  <= 1'b1;
              trs_io_pkg::bram_peek:        host_rd  <= 1'b1;
              trs_io_pkg::set_breakpoint:   bp_set   <= 1'b1;
              trs_io_pkg::clear_breakpoint: bp_clear <= 1'b1;
              default: ;
            endcase
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && state == st_params) begin
      params[8 * (2 - int'(idx)) +: 8] <= rx_byte;
    end
    if (rx_valid && state == st_idle) begin
      reply_byte <= (rx_byte == trs_io_pkg::get_version) ? trs_io_pkg::version_byte
                                                         : trs_io_pkg::cookie;
    end
  end

  assign host_addr  = {params.ram_view.addr_hi, params.ram_view.addr_lo};
  assign host_wdata = params.ram_view.data;

  // Peek data bypasses the reply register
  assign tx_load = reply_load | host_rdata_valid;
  assign tx_byte = host_rdata_valid ? host_rdata : reply_byte;

  a_host_rw_excl : assert property (
    @(posedge clk) disable iff (!arst_n) !(host_rd && host_wr)
  );

endmodule

//--- logic/shared_ram.sv
module shared_ram #(
  parameter int ram_addr_w = 15
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              host_rd,
  input  logic                              host_wr,
  input  logic [trs_io_pkg::bus_addr_w-1:0] host_addr,
  input  trs_io_pkg::byte_t                 host_wdata,
  output trs_io_pkg::byte_t                 host_rdata,
  output logic                              host_rdata_valid,
  input  logic                              bus_rd,
  input  logic                              bus_wr,
  input  logic [trs_io_pkg::bus_addr_w-1:0] trs_a,
  input  trs_io_pkg::byte_t                 trs_d_in,
  output trs_io_pkg::byte_t                 trs_d_out
);

  localparam int depth = 2 ** ram_addr_w;

  trs_io_pkg::byte_t     mem [depth];
  trs_io_pkg::byte_t     host_q;
  logic                  host_rd_q;
  logic [ram_addr_w-1:0] host_idx;
  logic [ram_addr_w-1:0] bus_idx;

  assign host_idx = host_addr[ram_addr_w-1:0];
  assign bus_idx  = trs_a[ram_addr_w-1:0];

  // Bus write is last so it wins a same-address collision
  always_ff @(posedge clk) begin
    if (host_wr) begin
      mem[host_idx] <= host_wdata;
    end
    if (bus_wr) begin
      mem[bus_idx] <= trs_d_in;
    end
  end

  // Host port has an extra output stage, bus port does not
  always_ff @(posedge clk) begin
    if (host_rd) begin
      host_q <= mem[host_idx];
    end
    if (host_rd_q) begin
      host_rdata <= host_q;
    end
    if (bus_rd) begin
      trs_d_out <= mem[bus_idx];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      host_rd_q        <= 1'b0;
      host_rdata_valid <= 1'b0;
    end else begin
      host_rd_q        <= host_rd;
      host_rdata_valid <= host_rd_q;
    end
  end

endmodule

//--- logic/bus_watch.sv
module bus_watch #(
  parameter int ram_addr_w      = 15,
  parameter int num_breakpoints = 8
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [trs_io_pkg::bus_addr_w-1:0] trs_a,
  input  logic                              trs_rd_n,
  input  logic                              trs_wr_n,
  input  trs_io_pkg::cmd_params_u           params,
  input  logic                              bp_set,
  input  logic                              bp_clear,
  input  logic                              bp_enable,
  input  logic                              bp_disable,
  input  logic                              resume,
  output logic                              bus_rd,
  output logic                              bus_wr,
  output logic                              halted
);

  localparam int slot_w = (num_breakpoints > 1) ? $clog2(num_breakpoints) : 1;

  localparam logic [1:0] st_run    = 2'b00;
  localparam logic [1:0] st_stop   = 2'b01;
  localparam logic [1:0] st_resume = 2'b11;

  logic [2:0]                          rd_r;
  logic [2:0]                          wr_r;
  logic                                in_window;
  logic                                chk_rd;
  logic                                chk_wr;
  logic [trs_io_pkg::bus_addr_w-1:0]   bp_addr [num_breakpoints];
  logic [num_breakpoints-1:0]          bp_active;
  logic                                bp_enabled;
  logic                                bp_hit;
  logic                                slot_ok;
  logic [slot_w-1:0]                   slot_idx;
  logic [1:0]                          state;
  logic [trs_io_pkg::bus_addr_w-1:0]   base_addr;
  logic                                base_match;
  logic                                serve;

  // Upper part of the address space covered by the RAM
  assign in_window = &trs_a[trs_io_pkg::bus_addr_w-1:ram_addr_w];

  // Strobe synchronizers, then a registered edge in the window
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_r   <= '1;
      wr_r   <= '1;
      chk_rd <= 1'b0;
      chk_wr <= 1'b0;
    end else begin
      rd_r   <= {rd_r[1:0], trs_rd_n};
      wr_r   <= {wr_r[1:0], trs_wr_n};
      chk_rd <= (rd_r[2:1] == 2'b10) && in_window;
      chk_wr <= (wr_r[2:1] == 2'b10) && in_window;
    end
  end

  assign slot_ok  = int'(params.bp_view.slot) < num_breakpoints;
  assign slot_idx = params.bp_view.slot[slot_w-1:0];

  always_ff @(posedge clk) begin
    if (bp_set && slot_ok) begin
      bp_addr[slot_idx] <= {params.bp_view.addr_hi, params.bp_view.addr_lo};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bp_active  <= '0;
      bp_enabled <= 1'b0;
    end else begin
      if (bp_set && slot_ok) begin
        bp_active[slot_idx] <= 1'b1;
      end
      if (bp_clear && slot_ok) begin
        bp_active[slot_idx] <= 1'b0;
      end
      if (bp_enable) begin
        bp_enabled <= 1'b1;
      end
      if (bp_disable) begin
        bp_enabled <= 1'b0;
      end
    end
  end

  always_comb begin
    bp_hit = 1'b0;
    for (int i = 0; i < num_breakpoints; i++) begin
      if (bp_active[i] && bp_addr[i] == trs_a) begin
        bp_hit = 1'b1;
      end
    end
  end

  assign base_match = (trs_a == base_addr);
  assign serve = ((state == st_run) && !(bp_enabled && bp_hit)) ||
                 ((state == st_resume) && base_match);

  always_ff @(posedge clk) begin
    if ((chk_rd || chk_wr) && state == st_run && bp_enabled && bp_hit) begin
      base_addr <= trs_a;
    end
  end

  // Serve pulses are registered so the state is back in run when they fire
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_run;
      bus_rd <= 1'b0;
      bus_wr <= 1'b0;
    end else begin
      bus_rd <= chk_rd && serve;
      bus_wr <= chk_wr && !chk_rd && serve;
      if (resume && state == st_stop) begin
        state <= st_resume;
      end
      if (chk_rd || chk_wr) begin
        if (state == st_run && bp_enabled && bp_hit) begin
          state <= st_stop;
        end else if (state == st_resume && base_match) begin
          state <= st_run;
        end
      end
    end
  end

  assign halted = (state != st_run);

  a_bus_rw_excl : assert property (
    @(posedge clk) disable iff (!arst_n) !(bus_rd && bus_wr)
  );

  a_no_serve_halted : assert property (
    @(posedge clk) disable iff (!arst_n) (bus_rd || bus_wr) |-> !halted
  );

endmodule

//--- logic/trs_io_top.sv
module trs_io_top #(
  parameter int ram_addr_w      = 15,
  parameter int num_breakpoints = 8
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              sck,
  input  logic                              cs_n,
  input  logic                              mosi,
  output logic                              miso,
  input  logic [trs_io_pkg::bus_addr_w-1:0] trs_a,
  input  logic                              trs_rd_n,
  input  logic                              trs_wr_n,
  input  trs_io_pkg::byte_t                 trs_d_in,
  output trs_io_pkg::byte_t                 trs_d_out,
  output logic                              halted
);

  trs_io_pkg::byte_t                 rx_byte;
  logic                              rx_valid;
  logic                              frame_start;
  trs_io_pkg::byte_t                 tx_byte;
  logic                              tx_load;
  logic                              host_rd;
  logic                              host_wr;
  logic [trs_io_pkg::bus_addr_w-1:0] host_addr;
  trs_io_pkg::byte_t                 host_wdata;
  trs_io_pkg::byte_t                 host_rdata;
  logic                              host_rdata_valid;
  trs_io_pkg::cmd_params_u           params;
  logic                              bp_set;
  logic                              bp_clear;
  logic                              bp_enable;
  logic                              bp_disable;
  logic                              resume;
  logic                              bus_rd;
  logic                              bus_wr;

  // Host SPI link
  spi_cmd_link u_spi (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .tx_byte     (tx_byte),
    .tx_load     (tx_load),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start)
  );

  cmd_parser u_parser (
    .clk              (clk),
    .arst_n           (arst_n),
    .rx_byte          (rx_byte),
    .rx_valid         (rx_valid),
    .frame_start      (frame_start),
    .tx_byte          (tx_byte),
    .tx_load          (tx_load),
    .host_rd          (host_rd),
    .host_wr          (host_wr),
    .host_addr        (host_addr),
    .host_wdata       (host_wdata),
    .host_rdata       (host_rdata),
    .host_rdata_valid (host_rdata_valid),
    .params           (params),
    .bp_set           (bp_set),
    .bp_clear         (bp_clear),
    .bp_enable        (bp_enable),
    .bp_disable       (bp_disable),
    .resume           (resume)
  );

  shared_ram #(
    .ram_addr_w (ram_addr_w)
  ) u_ram (
    .clk              (clk),
    .arst_n           (arst_n),
    .host_rd          (host_rd),
    .host_wr          (host_wr),
    .host_addr        (host_addr),
    .host_wdata       (host_wdata),
    .host_rdata       (host_rdata),
    .host_rdata_valid (host_rdata_valid),
    .bus_rd           (bus_rd),
    .bus_wr           (bus_wr),
    .trs_a            (trs_a),
    .trs_d_in         (trs_d_in),
    .trs_d_out        (trs_d_out)
  );

  // Z80 side with breakpoints
  bus_watch #(
    .ram_addr_w      (ram_addr_w),
    .num_breakpoints (num_breakpoints)
  ) u_watch (
    .clk        (clk),
    .arst_n     (arst_n),
    .trs_a      (trs_a),
    .trs_rd_n   (trs_rd_n),
    .trs_wr_n   (trs_wr_n),
    .params     (params),
    .bp_set     (bp_set),
    .bp_clear   (bp_clear),
    .bp_enable  (bp_enable),
    .bp_disable (bp_disable),
    .resume     (resume),
    .bus_rd     (bus_rd),
    .bus_wr     (bus_wr),
    .halted     (halted)
  );

endmodule

//--- bench/trs_io_tb.sv
module trs_io_tb;

  localparam int ram_addr_w      = 15;
  localparam int num_breakpoints = 8;
  localparam int clk_period      = 100;
  localparam int half_sck        = 10;
  localparam int strobe_cycles   = 6;

  // Step counts of the whole run set the watchdog time
  localparam int spi_bytes    = 85;
  localparam int bus_accesses = 14;
  localparam longint watchdog_time =
    2 * (spi_bytes * 200 + bus_accesses * 20) * clk_period;

  logic              clk;
  logic              arst_n;
  logic              sck;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  logic [15:0]       trs_a;
  logic              trs_rd_n;
  logic              trs_wr_n;
  trs_io_pkg::byte_t trs_d_in;
  trs_io_pkg::byte_t trs_d_out;
  logic              halted;

  logic              halt_allowed;
  // Byte the bus data output should hold after the last read
  trs_io_pkg::byte_t held_data;
  logic [15:0]       poke_addr [8];
  trs_io_pkg::byte_t poke_data [8];

  trs_io_top #(
    .ram_addr_w      (ram_addr_w),
    .num_breakpoints (num_breakpoints)
  ) UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .trs_a     (trs_a),
    .trs_rd_n  (trs_rd_n),
    .trs_wr_n  (trs_wr_n),
    .trs_d_in  (trs_d_in),
    .trs_d_out (trs_d_out),
    .halted    (halted)
  );

  always begin
    clk = 1'b0;
    #(clk_period / 2);
    clk = 1'b1;
    #(clk_period / 2);
  end

  task automatic report_mismatch(input string name, input trs_io_pkg::byte_t exp,
                                 input trs_io_pkg::byte_t act);
    $display("FAIL at time %0t: %s expected %h, got %h", $time, name, exp, act);
    $display("Simulation failed");
    $fatal(1, "Value mismatch on %s", name);
  endtask

  // Read data must not move while the card is halted
  a_hold_while_halted : assert property (
    @(posedge clk) disable iff (!arst_n) halted |-> (trs_d_out == held_data)
  ) else report_mismatch("trs_d_out", held_data, trs_d_out);

  // Only the breakpoint test may halt the card
  a_halt_expected : assert property (
    @(posedge clk) disable iff (!arst_n) halted |-> halt_allowed
  ) else report_mismatch("halted", 8'd0, 8'(halted));

  initial begin
    #(watchdog_time);
    $display("Watchdog expired before all tests finished at time %0t", $time);
    $display("Simulation failed");
    $fatal(1, "Watchdog timeout");
  end

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Mode 0, MSB first, miso sampled just before the rising edge
  task automatic spi_xfer(input trs_io_pkg::byte_t tx, output trs_io_pkg::byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      @(negedge clk);
      mosi = tx[i];
      wait_clocks(half_sck);
      rx[i] = miso;
      sck = 1'b1;
      wait_clocks(half_sck);
      sck = 1'b0;
    end
  endtask

  task automatic frame_open;
    @(negedge clk);
    cs_n = 1'b0;
    wait_clocks(half_sck);
  endtask

  task automatic frame_close;
    wait_clocks(half_sck);
    cs_n = 1'b1;
    wait_clocks(half_sck);
  endtask

  // Command byte, then a dummy byte that clocks the reply out
  task automatic query(input trs_io_pkg::byte_t cmd, output trs_io_pkg::byte_t reply);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(cmd, rx);
    spi_xfer(8'hff, reply);
    frame_close();
  endtask

  task automatic send_cmd(input trs_io_pkg::byte_t cmd);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(cmd, rx);
    frame_close();
  endtask

  task automatic poke(input logic [15:0] addr, input trs_io_pkg::byte_t data);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(trs_io_pkg::bram_poke, rx);
    spi_xfer(addr[7:0], rx);
    spi_xfer(addr[15:8], rx);
    spi_xfer(data, rx);
    frame_close();
  endtask

  task automatic peek(input logic [15:0] addr, output trs_io_pkg::byte_t data);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(trs_io_pkg::bram_peek, rx);
    spi_xfer(addr[7:0], rx);
    spi_xfer(addr[15:8], rx);
    spi_xfer(8'hff, data);
    frame_close();
  endtask

  task automatic set_bp(input trs_io_pkg::byte_t slot, input logic [15:0] addr);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(trs_io_pkg::set_breakpoint, rx);
    spi_xfer(slot, rx);
    spi_xfer(addr[7:0], rx);
    spi_xfer(addr[15:8], rx);
    frame_close();
  endtask

  task automatic clear_bp(input trs_io_pkg::byte_t slot);
    trs_io_pkg::byte_t rx;
    frame_open();
    spi_xfer(trs_io_pkg::clear_breakpoint, rx);
    spi_xfer(slot, rx);
    frame_close();
  endtask

  // Data must be on trs_d_out by the 6th cycle of the strobe
  task automatic bus_read(input logic [15:0] addr, input trs_io_pkg::byte_t exp,
                          input string name);
    @(negedge clk);
    trs_a    = addr;
    trs_rd_n = 1'b0;
    wait_clocks(strobe_cycles);
    assert (trs_d_out == exp) else report_mismatch(name, exp, trs_d_out);
    held_data = exp;
    trs_rd_n  = 1'b1;
    wait_clocks(strobe_cycles);
  endtask

  task automatic bus_write(input logic [15:0] addr, input trs_io_pkg::byte_t data);
    @(negedge clk);
    trs_a    = addr;
    trs_d_in = data;
    trs_wr_n = 1'b0;
    wait_clocks(strobe_cycles);
    trs_wr_n = 1'b1;
    wait_clocks(strobe_cycles);
  endtask

  initial begin
    trs_io_pkg::byte_t reply;
    logic [31:0]       rnd;
    logic [15:0]       low_addr;
    logic [15:0]       bp_addr;
    trs_io_pkg::byte_t bp_slot;

    void'($urandom(32'hdac6_e803));
    arst_n       = 1'b0;
    sck          = 1'b0;
    cs_n         = 1'b1;
    mosi         = 1'b0;
    trs_a        = '0;
    trs_rd_n     = 1'b1;
    trs_wr_n     = 1'b1;
    trs_d_in     = '0;
    halt_allowed = 1'b0;
    held_data    = '0;

    wait_clocks(5);
    assert (halted == 1'b0) else report_mismatch("halted", 8'd0, 8'(halted));
    assert (miso == 1'b0) else report_mismatch("miso", 8'd0, 8'(miso));
    arst_n = 1'b1;
    wait_clocks(5);

    // Identity replies
    query(trs_io_pkg::get_cookie, reply);
    assert (reply == trs_io_pkg::cookie)
      else report_mismatch("miso cookie", trs_io_pkg::cookie, reply);
    query(trs_io_pkg::get_version, reply);
    assert (reply == trs_io_pkg::version_byte)
      else report_mismatch("miso version", trs_io_pkg::version_byte, reply);

    // One poke per 4 KiB block keeps the addresses distinct
    // Index in the top data bits keeps the bytes distinct too
    for (int i = 0; i < 8; i++) begin
      rnd          = $urandom;
      poke_addr[i] = {1'b1, i[2:0], rnd[11:0]};
      poke_data[i] = {i[2:0], rnd[20:16]};
      poke(poke_addr[i], poke_data[i]);
    end
    for (int i = 0; i < 8; i++) begin
      peek(poke_addr[i], reply);
      assert (reply == poke_data[i]) else report_mismatch("miso peek", poke_data[i], reply);
    end

    // Bus reads inside the window
    for (int i = 0; i < 8; i++) begin
      bus_read(poke_addr[i], poke_data[i], "trs_d_out");
    end
    // Below the window, on an address that aliases a poked RAM byte
    low_addr = {1'b0, poke_addr[0][14:0]};
    bus_read(low_addr, held_data, "trs_d_out below window");

    // Bus write seen by a host peek
    rnd          = $urandom;
    poke_data[1] = poke_data[1] ^ {rnd[7:1], 1'b1};
    bus_write(poke_addr[1], poke_data[1]);
    peek(poke_addr[1], reply);
    assert (reply == poke_data[1]) else report_mismatch("miso peek", poke_data[1], reply);

    // Breakpoint hit, then resume
    rnd          = $urandom;
    bp_slot      = {5'd0, rnd[2:0]};
    bp_addr      = poke_addr[3];
    halt_allowed = 1'b1;
    set_bp(bp_slot, bp_addr);
    send_cmd(trs_io_pkg::enable_breakpoints);
    bus_read(bp_addr, held_data, "trs_d_out at breakpoint");
    assert (halted == 1'b1) else report_mismatch("halted", 8'd1, 8'(halted));
    send_cmd(trs_io_pkg::xray_resume);
    assert (halted == 1'b1) else report_mismatch("halted", 8'd1, 8'(halted));
    bus_read(bp_addr, poke_data[3], "trs_d_out after resume");
    assert (halted == 1'b0) else report_mismatch("halted", 8'd0, 8'(halted));
    halt_allowed = 1'b0;

    // Cleared slot, then a disabled table
    clear_bp(bp_slot);
    bus_read(bp_addr, poke_data[3], "trs_d_out after clear");
    set_bp(bp_slot, bp_addr);
    send_cmd(trs_io_pkg::disable_breakpoints);
    bus_read(bp_addr, poke_data[3], "trs_d_out after disable");
    assert (halted == 1'b0) else report_mismatch("halted", 8'd0, 8'(halted));

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- sources.f
logic/trs_io_pkg.sv
logic/spi_cmd_link.sv
logic/cmd_parser.sv
logic/shared_ram.sv
logic/bus_watch.sv
logic/trs_io_top.sv
bench/trs_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the trs_io testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module trs_io_tb \
  --Mdir obj_dir -o trs_io_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/trs_io_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation passed" "$log"; then
  exit 0
fi
exit 1
